//--- alu.sv
`default_nettype none

`include "cpu_macros.svh"

module alu (
  input  logic                   clock,
  input  logic                   reset,
  input  cpu_pkg::ctrl_t         ctrl,
  input  logic [`CPU_DATA_W-1:0] operand_a,
  input  logic [`CPU_DATA_W-1:0] operand_b,
  output logic [`CPU_DATA_W-1:0] result
);

  logic [`CPU_DATA_W-1:0] alu_next;
  logic [4:0]             shamt;

  assign shamt = operand_b[4:0];

  always_comb begin
    alu_next = '0;
    case (ctrl.opcode)
      cpu_pkg::OP_ALU: begin
        case (ctrl.sub_op)
          cpu_pkg::ADD:   alu_next = operand_a + operand_b;
          cpu_pkg::SUB:   alu_next = operand_a - operand_b;
          cpu_pkg::AND:   alu_next = operand_a & operand_b;
          cpu_pkg::OR:    alu_next = operand_a | operand_b;
          cpu_pkg::XOR:   alu_next = operand_a ^ operand_b;
          cpu_pkg::SRLI:  alu_next = operand_a >> shamt;
          cpu_pkg::SLLI:  alu_next = operand_a << shamt;
          // left part drops out when shamt is zero
          cpu_pkg::ROTRI: alu_next = (operand_a >> shamt) |
                                     (operand_a << (6'd32 - {1'b0, shamt}));
          default:        alu_next = '0;
        endcase
      end
      cpu_pkg::OP_ADDI: alu_next = operand_a + operand_b;
      cpu_pkg::OP_ORI:  alu_next = operand_a | operand_b;
      cpu_pkg::OP_XORI: alu_next = operand_a ^ operand_b;
      default:          alu_next = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result <= '0;
    end else if (ctrl.alu_execute) begin
      result <= alu_next;
    end
  end

endmodule

`default_nettype wire

//--- cpu_assertions.sv
`default_nettype none

module cpu_assertions (
  input logic             clock,
  input logic             reset,
  input cpu_pkg::commit_t commit
);

  // count of failed assertions, seen by the testbench
  int fail_count = 0;

  // one commit strobe per instruction
  commit_single_cycle: assert property (
    @(posedge clock) disable iff (reset) commit.valid |=> !commit.valid
  ) else begin
    fail_count = fail_count + 1;
    $error("commit valid high in two consecutive cycles");
  end

  commit_we_needs_valid: assert property (
    @(posedge clock) disable iff (reset) commit.we |-> commit.valid
  ) else begin
    fail_count = fail_count + 1;
    $error("commit we high without commit valid");
  end

  commit_quiet_in_reset: assert property (
    @(posedge clock) reset |=> !commit.valid
  ) else begin
    fail_count = fail_count + 1;
    $error("commit valid high after a reset cycle");
  end

endmodule

`default_nettype wire

//--- cpu_core.sv
`default_nettype none

`include "cpu_macros.svh"

module cpu_core (
  input  logic              clock,
  input  logic              reset,
  input  logic              run,
  input  cpu_pkg::prog_wr_t prog,
  output cpu_pkg::commit_t  commit
);

  cpu_pkg::ctrl_state_e   state;
  cpu_pkg::ctrl_t         ctrl;
  cpu_pkg::prog_wr_t      prog_gated;
  logic [`CPU_PC_W-1:0]   pc;
  logic [`CPU_DATA_W-1:0] ir;
  logic [`CPU_DATA_W-1:0] src1;
  logic [`CPU_DATA_W-1:0] src2;
  logic [`CPU_DATA_W-1:0] operand_b;
  logic [`CPU_DATA_W-1:0] imm_value;
  logic [`CPU_DATA_W-1:0] result;
  logic [`CPU_DATA_W-1:0] wb_data;

  // no loading while the core runs
  always_comb begin
    prog_gated       = prog;
    prog_gated.valid = prog.valid && !run;
  end

  // pc wraps with the memory depth
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (state == cpu_pkg::WRITE) begin
      pc <= pc + 1'b1;
    end
  end

  assign wb_data = ctrl.wb_src2 ? imm_value : result;

  always_comb begin
    commit.valid = (state == cpu_pkg::WRITE);
    commit.we    = ctrl.reg_write;
    commit.pc    = pc;
    commit.rd    = ctrl.rt;
    commit.data  = wb_data;
  end

  ir_controller u_ir_controller (
    .clock (clock),
    .reset (reset),
    .run   (run),
    .ir    (ir),
    .state (state),
    .ctrl  (ctrl)
  );

  instr_mem u_instr_mem (
    .clock (clock),
    .prog  (prog_gated),
    .addr  (pc),
    .rdata (ir)
  );

  reg_file u_reg_file (
    .clock (clock),
    .reset (reset),
    .ctrl  (ctrl),
    .wdata (wb_data),
    .src1  (src1),
    .src2  (src2)
  );

  imm_select u_imm_select (
    .ctrl      (ctrl),
    .src2      (src2),
    .operand_b (operand_b),
    .imm_value (imm_value)
  );

  alu u_alu (
    .clock     (clock),
    .reset     (reset),
    .ctrl      (ctrl),
    .operand_a (src1),
    .operand_b (operand_b),
    .result    (result)
  );

endmodule

`default_nettype wire

//--- cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path and instruction word width
`define CPU_DATA_W 32

// pc and program memory address width
`define CPU_PC_W 10

// register file address width
`define CPU_REG_AW 5

// derived register count
`define CPU_NUM_REGS (1 << `CPU_REG_AW)

// program memory words, one per pc value
`define CPU_MEM_DEPTH 1024

`endif

//--- cpu_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

  typedef enum logic [1:0] {
    STOP  = 2'b00,
    FETCH = 2'b01,
    EXEC  = 2'b10,
    WRITE = 2'b11
  } ctrl_state_e;

  // major opcode, instr[30:25]
  typedef enum logic [5:0] {
    OP_ALU  = 6'b100000,
    OP_ADDI = 6'b101000,
    OP_ORI  = 6'b101100,
    OP_XORI = 6'b101011,
    OP_MOVI = 6'b100010
  } opcode_e;

  // sub-opcode under OP_ALU, instr[4:0]
  typedef enum logic [4:0] {
    ADD   = 5'b00000,
    SUB   = 5'b00001,
    AND   = 5'b00010,
    XOR   = 5'b00011,
    OR    = 5'b00100,
    SLLI  = 5'b01000,
    SRLI  = 5'b01001,
    ROTRI = 5'b01011
  } sub_op_e;

  typedef enum logic [1:0] {
    IMM5_ZE  = 2'b00,
    IMM15_SE = 2'b01,
    IMM15_ZE = 2'b10,
    IMM20_SE = 2'b11
  } imm_sel_e;

  typedef struct packed {
    logic                   reg_read;
    logic                   alu_execute;
    logic                   reg_write;
    opcode_e                opcode;
    sub_op_e                sub_op;
    imm_sel_e               imm_sel;
    logic                   use_imm;
    logic                   wb_src2;
    logic [`CPU_REG_AW-1:0] rt;
    logic [`CPU_REG_AW-1:0] ra;
    logic [`CPU_REG_AW-1:0] rb;
    // raw instr[19:0], source of the wide immediates
    logic [19:0]            imm_raw;
  } ctrl_t;

  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic [`CPU_PC_W-1:0]   pc;
    logic [`CPU_REG_AW-1:0] rd;
    logic [`CPU_DATA_W-1:0] data;
  } commit_t;

  typedef struct packed {
    logic                   valid;
    logic [`CPU_PC_W-1:0]   addr;
    logic [`CPU_DATA_W-1:0] word;
  } prog_wr_t;

endpackage

`default_nettype wire

//--- cpu_tb.sv
`default_nettype none

`include "cpu_macros.svh"

module cpu_tb;

  localparam int NUM_INSTR      = 200;
  localparam int DRIVE_DELAY    = 2;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 4 + NUM_INSTR + 100;

  // encodings as given for the core
  localparam logic [5:0] OPC_ALU  = 6'b100000;
  localparam logic [5:0] OPC_ADDI = 6'b101000;
  localparam logic [5:0] OPC_ORI  = 6'b101100;
  localparam logic [5:0] OPC_XORI = 6'b101011;
  localparam logic [5:0] OPC_MOVI = 6'b100010;
  localparam logic [4:0] SUB_ADD   = 5'b00000;
  localparam logic [4:0] SUB_SUB   = 5'b00001;
  localparam logic [4:0] SUB_AND   = 5'b00010;
  localparam logic [4:0] SUB_XOR   = 5'b00011;
  localparam logic [4:0] SUB_OR    = 5'b00100;
  localparam logic [4:0] SUB_SLLI  = 5'b01000;
  localparam logic [4:0] SUB_SRLI  = 5'b01001;
  localparam logic [4:0] SUB_ROTRI = 5'b01011;

  logic              clock;
  logic              reset;
  logic              run;
  cpu_pkg::prog_wr_t prog;
  cpu_pkg::commit_t  commit;

  int                     seed = 88125;
  int                     cycle_count = 0;
  logic [`CPU_DATA_W-1:0] program_words [NUM_INSTR];
  logic [`CPU_DATA_W-1:0] model_regs [`CPU_NUM_REGS];

  tb_clock_gen #(.PERIOD(20)) u_tb_clock_gen (.clock(clock));

  cpu_core u_cpu_core (
    .clock  (clock),
    .reset  (reset),
    .run    (run),
    .prog   (prog),
    .commit (commit)
  );

  bind cpu_core cpu_assertions u_cpu_assertions (
    .clock  (clock),
    .reset  (reset),
    .commit (commit)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] encode_alu(input logic [4:0] sub, input logic [4:0] rt,
                                             input logic [4:0] ra, input logic [4:0] rb);
    return {1'b0, OPC_ALU, rt, ra, rb, 5'b00000, sub};
  endfunction

  function automatic logic [31:0] encode_imm15(input logic [5:0] op, input logic [4:0] rt,
                                               input logic [4:0] ra, input logic [14:0] imm);
    return {1'b0, op, rt, ra, imm};
  endfunction

  task automatic make_instr(output logic [31:0] word);
    logic [31:0] r1;
    logic [31:0] r2;
    logic [4:0]  rt;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [4:0]  shamt;
    int          kind;
    r1 = $random(seed);
    r2 = $random(seed);
    rt = r1[4:0];
    ra = r1[9:5];
    rb = r1[14:10];
    shamt = (rb == 5'd0) ? 5'd1 : rb;
    kind = int'(r1[31:20]) % 13;
    case (kind)
      0:  word = encode_alu(SUB_ADD, rt, ra, rb);
      1:  word = encode_alu(SUB_SUB, rt, ra, rb);
      2:  word = encode_alu(SUB_AND, rt, ra, rb);
      3:  word = encode_alu(SUB_OR, rt, ra, rb);
      4:  word = encode_alu(SUB_XOR, rt, ra, rb);
      5:  word = encode_alu(SUB_SRLI, rt, ra, shamt);
      6:  word = encode_alu(SUB_SLLI, rt, ra, shamt);
      7:  word = encode_alu(SUB_ROTRI, rt, ra, shamt);
      // nop, srli by zero
      8:  word = encode_alu(SUB_SRLI, rt, ra, 5'd0);
      9:  word = encode_imm15(OPC_ADDI, rt, ra, r2[14:0]);
      10: word = encode_imm15(OPC_ORI, rt, ra, r2[14:0]);
      11: word = encode_imm15(OPC_XORI, rt, ra, r2[14:0]);
      default: word = {1'b0, OPC_MOVI, rt, r2[19:0]};
    endcase
  endtask

  // reference model, one instruction in program order
  task automatic model_step(input logic [31:0] word, output logic exp_we,
                            output logic [4:0] exp_rd, output logic [31:0] exp_data);
    logic [5:0]  op;
    logic [4:0]  sub;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  imm5;
    logic [63:0] doubled;
    op = word[30:25];
    sub = word[4:0];
    a = model_regs[word[19:15]];
    b = model_regs[word[14:10]];
    imm5 = word[14:10];
    doubled = {a, a} >> imm5;
    exp_we = 1'b1;
    exp_rd = word[24:20];
    exp_data = 32'd0;
    case (op)
      OPC_ALU: begin
        case (sub)
          SUB_ADD:   exp_data = a + b;
          SUB_SUB:   exp_data = a - b;
          SUB_AND:   exp_data = a & b;
          SUB_OR:    exp_data = a | b;
          SUB_XOR:   exp_data = a ^ b;
          SUB_SLLI:  exp_data = a << imm5;
          SUB_ROTRI: exp_data = doubled[31:0];
          default: begin
            exp_data = a >> imm5;
            exp_we = (imm5 != 5'd0);
          end
        endcase
      end
      OPC_ADDI: exp_data = a + {{17{word[14]}}, word[14:0]};
      OPC_ORI:  exp_data = a | {17'd0, word[14:0]};
      OPC_XORI: exp_data = a ^ {17'd0, word[14:0]};
      default:  exp_data = {{12{word[19]}}, word[19:0]};
    endcase
    if (exp_we) begin
      model_regs[exp_rd] = exp_data;
    end
  endtask

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  // no commit while idle or loading
  always @(negedge clock) begin
    if (!run) begin
      check_value("commit.valid", 32'(commit.valid), 32'd0);
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("timeout: the program did not finish committing in time");
    $display("TESTS FAILED");
    $fatal(1);
  end

  initial begin
    logic        exp_we;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    int          last_cycle;
    reset = 1'b1;
    run = 1'b0;
    prog = '0;
    last_cycle = 0;
    for (int i = 0; i < `CPU_NUM_REGS; i++) begin
      model_regs[i] = 32'd0;
    end
    for (int i = 0; i < NUM_INSTR; i++) begin
      make_instr(program_words[i]);
    end

    repeat (3) @(posedge clock);
    #DRIVE_DELAY reset = 1'b0;

    for (int i = 0; i < NUM_INSTR; i++) begin
      @(posedge clock);
      #DRIVE_DELAY;
      prog.valid = 1'b1;
      prog.addr = 10'(i);
      prog.word = program_words[i];
    end
    @(posedge clock);
    #DRIVE_DELAY prog = '0;
    @(posedge clock);
    #DRIVE_DELAY run = 1'b1;

    for (int n = 0; n < NUM_INSTR; n++) begin
      @(negedge clock);
      while (commit.valid !== 1'b1) @(negedge clock);
      if (n > 0) begin
        check_value("commit spacing", 32'(cycle_count - last_cycle), 32'd4);
      end
      last_cycle = cycle_count;
      model_step(program_words[n], exp_we, exp_rd, exp_data);
      check_value("commit.pc", 32'(commit.pc), 32'(n));
      check_value("commit.we", 32'(commit.we), 32'(exp_we));
      check_value("commit.rd", 32'(commit.rd), 32'(exp_rd));
      check_value("commit.data", commit.data, exp_data);
    end

    // let the assertions see the cycles after the last commit
    repeat (2) @(negedge clock);

    if (u_cpu_core.u_cpu_assertions.fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- imm_select.sv
`default_nettype none

`include "cpu_macros.svh"

module imm_select (
  input  cpu_pkg::ctrl_t         ctrl,
  input  logic [`CPU_DATA_W-1:0] src2,
  output logic [`CPU_DATA_W-1:0] operand_b,
  output logic [`CPU_DATA_W-1:0] imm_value
);

  logic [4:0]  imm5;
  logic [14:0] imm15;
  logic [19:0] imm20;

  assign imm5  = ctrl.rb;
  assign imm15 = ctrl.imm_raw[14:0];
  assign imm20 = ctrl.imm_raw;

  always_comb begin
    case (ctrl.imm_sel)
      cpu_pkg::IMM5_ZE:  imm_value = {{(`CPU_DATA_W-5){1'b0}}, imm5};
      cpu_pkg::IMM15_SE: imm_value = {{(`CPU_DATA_W-15){imm15[14]}}, imm15};
      cpu_pkg::IMM15_ZE: imm_value = {{(`CPU_DATA_W-15){1'b0}}, imm15};
      default:           imm_value = {{(`CPU_DATA_W-20){imm20[19]}}, imm20};
    endcase
  end

  assign operand_b = ctrl.use_imm ? imm_value : src2;

endmodule

`default_nettype wire

//--- instr_mem.sv
`default_nettype none

`include "cpu_macros.svh"

module instr_mem (
  input  logic                   clock,
  input  cpu_pkg::prog_wr_t      prog,
  input  logic [`CPU_PC_W-1:0]   addr,
  output logic [`CPU_DATA_W-1:0] rdata
);

  logic [`CPU_DATA_W-1:0] mem [`CPU_MEM_DEPTH];

  // load port, one word per strobe
  always_ff @(posedge clock) begin
    if (prog.valid) begin
      mem[prog.addr] <= prog.word;
    end
  end

  // read every cycle, word valid one cycle after addr
  always_ff @(posedge clock) begin
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

//--- ir_controller.sv
`default_nettype none

`include "cpu_macros.svh"

module ir_controller (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   run,
  input  logic [`CPU_DATA_W-1:0] ir,
  output cpu_pkg::ctrl_state_e   state,
  output cpu_pkg::ctrl_t         ctrl
);

  cpu_pkg::ctrl_state_e   next_state;
  logic [`CPU_DATA_W-1:0] ir_q;
  logic [`CPU_DATA_W-1:0] instr;
  cpu_pkg::opcode_e       opcode;
  cpu_pkg::sub_op_e       sub_op;
  logic [4:0]             imm5;
  logic                   is_shift;
  logic                   is_nop;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= cpu_pkg::STOP;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    case (state)
      cpu_pkg::STOP:  next_state = run ? cpu_pkg::FETCH : cpu_pkg::STOP;
      cpu_pkg::FETCH: next_state = cpu_pkg::EXEC;
      cpu_pkg::EXEC:  next_state = cpu_pkg::WRITE;
      default:        next_state = cpu_pkg::STOP;
    endcase
  end

  // instruction register, loaded as fetch ends
  always_ff @(posedge clock) begin
    if (state == cpu_pkg::FETCH) begin
      ir_q <= ir;
    end
  end

  // during fetch the register addresses come straight from memory,
  // so the operand read at the end of fetch sees the new instruction
  assign instr = (state == cpu_pkg::FETCH) ? ir : ir_q;

  assign opcode   = cpu_pkg::opcode_e'(instr[30:25]);
  assign sub_op   = cpu_pkg::sub_op_e'(instr[4:0]);
  assign imm5     = instr[14:10];
  assign is_shift = (sub_op == cpu_pkg::SRLI) || (sub_op == cpu_pkg::SLLI) ||
                    (sub_op == cpu_pkg::ROTRI);
  // srli by zero is the nop encoding
  assign is_nop   = (opcode == cpu_pkg::OP_ALU) && (sub_op == cpu_pkg::SRLI) &&
                    (imm5 == 5'd0);

  always_comb begin
    ctrl             = '0;
    ctrl.reg_read    = (state == cpu_pkg::FETCH);
    ctrl.alu_execute = (state == cpu_pkg::EXEC);
    ctrl.reg_write   = (state == cpu_pkg::WRITE) && !is_nop;
    ctrl.opcode      = opcode;
    ctrl.sub_op      = sub_op;
    ctrl.rt          = instr[24:20];
    ctrl.ra          = instr[19:15];
    ctrl.rb          = instr[14:10];
    ctrl.imm_raw     = instr[19:0];
    ctrl.imm_sel     = cpu_pkg::IMM5_ZE;
    ctrl.use_imm     = 1'b0;
    ctrl.wb_src2     = 1'b0;

    case (opcode)
      cpu_pkg::OP_ALU: begin
        ctrl.use_imm = is_shift;
      end
      cpu_pkg::OP_ADDI: begin
        ctrl.imm_sel = cpu_pkg::IMM15_SE;
        ctrl.use_imm = 1'b1;
      end
      cpu_pkg::OP_ORI, cpu_pkg::OP_XORI: begin
        ctrl.imm_sel = cpu_pkg::IMM15_ZE;
        ctrl.use_imm = 1'b1;
      end
      cpu_pkg::OP_MOVI: begin
        ctrl.imm_sel = cpu_pkg::IMM20_SE;
        ctrl.use_imm = 1'b1;
        ctrl.wb_src2 = 1'b1;
      end
      default: begin
        // unknown opcode, register operand
        ctrl.use_imm = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

`include "cpu_macros.svh"

module reg_file (
  input  logic                   clock,
  input  logic                   reset,
  input  cpu_pkg::ctrl_t         ctrl,
  input  logic [`CPU_DATA_W-1:0] wdata,
  output logic [`CPU_DATA_W-1:0] src1,
  output logic [`CPU_DATA_W-1:0] src2
);

  logic [`CPU_DATA_W-1:0] regs [`CPU_NUM_REGS];

  // r0 is an ordinary register here
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.reg_write) begin
      regs[ctrl.rt] <= wdata;
    end
  end

  // operands captured at the end of fetch
  always_ff @(posedge clock) begin
    if (ctrl.reg_read) begin
      src1 <= regs[ctrl.ra];
      src2 <= regs[ctrl.rb];
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the cpu_tb simulation with Verilator

verilator --binary --timing --assert -f vlog.f --top-module cpu_tb \
  --Mdir obj_dir -o cpu_tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/cpu_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
exit 0

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 20
) (
  output logic clock
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
cpu_pkg.sv
ir_controller.sv
instr_mem.sv
reg_file.sv
imm_select.sv
alu.sv
cpu_core.sv
tb_clock_gen.sv
cpu_assertions.sv
cpu_tb.sv
